// File: common/bus_mem_config.svh
`ifndef BUS_MEM_CONFIG_SVH
`define BUS_MEM_CONFIG_SVH

// width of the byte index into the array
// 11 bits give 2048 bytes, i.e. 512 words
`define MEM_ADDR_BITS 11

// first address of the boot region
// everything at or above it is folded onto the reset vector
`define BOOT_BASE 32'hBFC00000

// word at which the boot region lands
// byte address 32'h200
`define RESET_VECTOR_WORD 128

// width of the per-request wait-state count
// up to 15 stall cycles
`define STALL_BITS 4

`endif

// File: common/bus_mem_pkg.sv
`default_nettype none

package bus_mem_pkg;

	`include "bus_mem_config.svh"

	// one bus data word
	typedef logic [31:0] word_t;

	// one enable per byte lane, lane 0 is the low byte
	typedef logic [3:0] byte_en_t;

	// byte index into the storage array
	typedef logic [`MEM_ADDR_BITS-1:0] byte_idx_t;

	// number of wait states requested by the master
	typedef logic [`STALL_BITS-1:0] stall_cnt_t;

	// raw request as it appears on the bus
	typedef struct packed {
		logic [31:0] address;
		logic read;
		logic write;
		word_t writedata;
		byte_en_t byteenable;
		stall_cnt_t num_stalls;
	} bus_req_t;

	// request after address decoding
	typedef struct packed {
		byte_idx_t index;
		// whole word lies inside the array
		logic in_range;
		logic read;
		logic write;
		word_t writedata;
		byte_en_t byteenable;
		stall_cnt_t num_stalls;
	} mem_req_t;

	// wait-state controller states
	typedef enum logic [1:0] {
		// waiting for read or write
		ws_idle,
		// counting stall cycles, waitrequest held high
		ws_busy,
		// access finished, waitrequest low for one cycle
		ws_done
	} ws_state_t;

endpackage

`default_nettype wire

// File: hw/bus_request_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_mem_config.svh"

module bus_request_decode (
	input bus_mem_pkg::bus_req_t req,
	output bus_mem_pkg::mem_req_t mreq
);
	import bus_mem_pkg::*;

	// byte offset of the reset vector word inside the array
	localparam logic [31:0] boot_byte_offset = 32'(`RESET_VECTOR_WORD) * 32'd4;

	// last byte index at which all four bytes of a word still fit
	localparam logic [31:0] last_word_start = (32'd1 << `MEM_ADDR_BITS) - 32'd4;

	logic boot_access;
	logic [31:0] byte_addr;

	// boot region sits at the top of the address map
	assign boot_access = (req.address >= `BOOT_BASE);

	// fold the boot region onto word 128
	// data addresses go through unchanged
	always_comb begin
		if (boot_access) begin
			byte_addr = req.address - `BOOT_BASE + boot_byte_offset;
		end else begin
			byte_addr = req.address;
		end
	end

	always_comb begin
		// low bits select the byte, upper bits only matter for the range check
		mreq.index = byte_addr[`MEM_ADDR_BITS-1:0];
		// the full-width address decides the range, so nothing aliases
		mreq.in_range = (byte_addr <= last_word_start);
		// remaining fields pass straight across
		mreq.read = req.read;
		mreq.write = req.write;
		mreq.writedata = req.writedata;
		mreq.byteenable = req.byteenable;
		mreq.num_stalls = req.num_stalls;
	end

endmodule

`default_nettype wire

// File: hw/wait_state_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wait_state_ctrl (
	input logic clk,
	input logic reset,
	input bus_mem_pkg::mem_req_t mreq_in,
	output bus_mem_pkg::mem_req_t mreq_out,
	output logic waitrequest,
	output logic access
);
	import bus_mem_pkg::*;

	ws_state_t state;
	ws_state_t state_next;

	// running stall count and the count latched at request start
	stall_cnt_t stall_cnt;
	stall_cnt_t stall_cnt_next;
	stall_cnt_t stall_target;

	logic req_valid;
	logic count_met;
	logic start_busy;

	// master holds read or write while the access is pending
	assign req_valid = mreq_in.read | mreq_in.write;

	// busy phase ends once the counter reaches the latched count
	assign count_met = (stall_cnt == stall_target);

	// a request with stalls leaves idle for busy
	assign start_busy = (state == ws_idle) && req_valid && (mreq_in.num_stalls != '0);

	// the request stays steady during the access, storage sees it unchanged
	assign mreq_out = mreq_in;

	// stretch every cycle of a request except the completion cycle
	assign waitrequest = req_valid && (state != ws_done);

	always_comb begin
		state_next = state;
		stall_cnt_next = stall_cnt;
		access = 1'b0;
		case (state)
			ws_idle: begin
				if (req_valid) begin
					if (mreq_in.num_stalls == '0) begin
						// zero stalls, access on this edge
						access = 1'b1;
						state_next = ws_done;
					end else begin
						// first stall cycle is already counted here
						stall_cnt_next = stall_cnt_t'(1);
						state_next = ws_busy;
					end
				end
			end
			ws_busy: begin
				if (!req_valid) begin
					// request withdrawn mid-count, finish without touching storage
					stall_cnt_next = '0;
					state_next = ws_done;
				end else if (!count_met) begin
					stall_cnt_next = stall_cnt + 1'b1;
				end else begin
					access = 1'b1;
					stall_cnt_next = '0;
					state_next = ws_done;
				end
			end
			ws_done: begin
				// one cycle with waitrequest low, then ready again
				state_next = ws_idle;
			end
			default: begin
				state_next = ws_idle;
				stall_cnt_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ws_idle;
			stall_cnt <= '0;
		end else begin
			state <= state_next;
			stall_cnt <= stall_cnt_next;
		end
	end

	// capture the requested count when leaving idle
	always_ff @(posedge clk) begin
		if (reset) begin
			stall_target <= '0;
		end else if (start_busy) begin
			stall_target <= mreq_in.num_stalls;
		end
	end

endmodule

`default_nettype wire

// File: hw/byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_mem_config.svh"

module byte_lane_ram (
	input logic clk,
	input logic reset,
	input bus_mem_pkg::mem_req_t mreq,
	input logic access,
	output bus_mem_pkg::word_t readdata
);
	import bus_mem_pkg::*;

	localparam int unsigned mem_bytes = 2 ** `MEM_ADDR_BITS;

	// byte storage, little-endian within each word
	logic [7:0] mem [mem_bytes];

	// index of each of the four lanes
	byte_idx_t lane_idx [4];

	// lane-masked view of the addressed word
	word_t masked_word;

	logic do_write;
	logic do_read;

	// out-of-range writes are dropped but still take their wait states
	assign do_write = access && mreq.write && mreq.in_range;
	assign do_read = access && mreq.read;

	// lane k lives at index + k, range check keeps this from wrapping
	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			lane_idx[lane] = mreq.index + byte_idx_t'(lane);
		end
	end

	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			// disabled lanes and out-of-range reads return zero
			if (mreq.in_range && mreq.byteenable[lane]) begin
				masked_word[lane*8 +: 8] = mem[lane_idx[lane]];
			end else begin
				masked_word[lane*8 +: 8] = 8'h00;
			end
		end
	end

	// byte-enabled write, only on the access edge
	always_ff @(posedge clk) begin
		if (do_write) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (mreq.byteenable[lane]) begin
					mem[lane_idx[lane]] <= mreq.writedata[lane*8 +: 8];
				end
			end
		end
	end

	// read word registered on the access edge
	// it stays put until the next read, so the done cycle sees it
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (do_read) begin
			readdata <= masked_word;
		end
	end

endmodule

`default_nettype wire

// File: hw/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory (
	input logic clk,
	input logic reset,
	input logic [31:0] address,
	input logic read,
	input logic write,
	input bus_mem_pkg::word_t writedata,
	input bus_mem_pkg::byte_en_t byteenable,
	input bus_mem_pkg::stall_cnt_t num_stalls,
	output logic waitrequest,
	output bus_mem_pkg::word_t readdata
);
	import bus_mem_pkg::*;

	// raw request gathered from the ports
	bus_req_t bus_req;

	// decoded request before and after the controller
	mem_req_t dec_req;
	mem_req_t ram_req;

	// one-cycle strobe that lets the storage act
	logic access;

	assign bus_req.address = address;
	assign bus_req.read = read;
	assign bus_req.write = write;
	assign bus_req.writedata = writedata;
	assign bus_req.byteenable = byteenable;
	assign bus_req.num_stalls = num_stalls;

	// stage 1, address fold and range check
	bus_request_decode u_decode (
		.req (bus_req),
		.mreq (dec_req)
	);

	// stage 2, wait states and access timing
	wait_state_ctrl u_wait_ctrl (
		.clk (clk),
		.reset (reset),
		.mreq_in (dec_req),
		.mreq_out (ram_req),
		.waitrequest (waitrequest),
		.access (access)
	);

	// stage 3, byte storage and read word
	byte_lane_ram u_ram (
		.clk (clk),
		.reset (reset),
		.mreq (ram_req),
		.access (access),
		.readdata (readdata)
	);

endmodule

`default_nettype wire

// File: verification/bus_memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_mem_config.svh"

module bus_memory_tb;
	import bus_mem_pkg::*;

	localparam int unsigned reset_cycles = 8;
	localparam int unsigned random_rows = 24;
	localparam int unsigned array_bytes = 2 ** `MEM_ADDR_BITS;

	// wide enough for num_stalls + 1
	typedef logic [`STALL_BITS:0] wait_cnt_t;

	// one table row, expected values come from the model array
	typedef struct packed {
		logic is_write;
		logic [31:0] address;
		byte_en_t byteenable;
		word_t writedata;
		stall_cnt_t stalls;
		word_t exp_data;
		wait_cnt_t exp_wait;
	} row_t;

	logic clk;
	logic reset;
	logic [31:0] address;
	logic read;
	logic write;
	word_t writedata;
	byte_en_t byteenable;
	stall_cnt_t num_stalls;
	logic waitrequest;
	word_t readdata;

	row_t rows [$];
	// reference copy of the byte array
	logic [7:0] model_mem [array_bytes];
	logic table_ready;

	bus_memory dut (
		.clk (clk),
		.reset (reset),
		.address (address),
		.read (read),
		.write (write),
		.writedata (writedata),
		.byteenable (byteenable),
		.num_stalls (num_stalls),
		.waitrequest (waitrequest),
		.readdata (readdata)
	);

	always #5 clk = ~clk;

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			report_failure($sformatf("FAIL %s expected 0x%08h got 0x%08h", name, exp, got));
		end
	endtask

	task automatic check_wait(input wait_cnt_t exp, input wait_cnt_t got);
		if (got !== exp) begin
			report_failure($sformatf("FAIL waitrequest cycles expected 0x%0h got 0x%0h", exp, got));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			report_failure($sformatf("FAIL %s expected 0x%0h got 0x%0h", name, exp, got));
		end
	endtask

	// boot region lands on the reset vector word, data addresses map straight through
	function automatic logic [31:0] fold_address(input logic [31:0] addr);
		if (addr >= `BOOT_BASE) begin
			return addr - `BOOT_BASE + `RESET_VECTOR_WORD * 4;
		end
		return addr;
	endfunction

	// apply one row to the model, returns the expected read word
	function automatic word_t model_access(input row_t row);
		logic [31:0] offset;
		logic fits;
		word_t result;
		offset = fold_address(row.address);
		// all four bytes of the word have to lie inside the array
		fits = (offset <= array_bytes - 4);
		result = '0;
		for (int lane = 0; lane < 4; lane++) begin
			if (fits && row.byteenable[lane]) begin
				if (row.is_write) begin
					model_mem[offset + lane] = row.writedata[lane*8 +: 8];
				end else begin
					result[lane*8 +: 8] = model_mem[offset + lane];
				end
			end
		end
		return result;
	endfunction

	task automatic add_row(input logic is_write, input logic [31:0] addr, input byte_en_t be,
		input word_t data, input stall_cnt_t stalls);
		row_t row;
		row = '0;
		row.is_write = is_write;
		row.address = addr;
		row.byteenable = be;
		row.writedata = data;
		row.stalls = stalls;
		row.exp_data = model_access(row);
		row.exp_wait = wait_cnt_t'(stalls) + 1'b1;
		rows.push_back(row);
	endtask

	// one bus transfer, counts cycles with waitrequest high
	task automatic bus_access(input row_t row, output wait_cnt_t cycles, output word_t data);
		cycles = '0;
		@(negedge clk);
		address = row.address;
		read = ~row.is_write;
		write = row.is_write;
		writedata = row.writedata;
		byteenable = row.byteenable;
		num_stalls = row.stalls;
		#1;
		while (waitrequest) begin
			cycles = cycles + 1'b1;
			@(negedge clk);
			#1;
		end
		// completion cycle, read word is valid here
		data = readdata;
		@(negedge clk);
		read = 1'b0;
		write = 1'b0;
	endtask

	// watchdog, rows x (16 + 4) cycles plus reset
	initial begin
		wait (table_ready);
		#((rows.size() * 20 + reset_cycles + 4) * 10);
		report_failure("watchdog expired before all table rows completed");
	end

	initial begin
		wait_cnt_t cycles;
		word_t data;
		logic [31:0] offset;
		logic [31:0] base;
		clk = 1'b0;
		reset = 1'b1;
		address = '0;
		read = 1'b0;
		write = 1'b0;
		writedata = '0;
		byteenable = '0;
		num_stalls = '0;
		table_ready = 1'b0;
		void'($urandom(32'h6b87_781d));

		// full words at stall counts 0, 1, 7, 15
		add_row(1'b1, 32'h100, 4'hF, 32'h0123_4567, 4'd0);
		add_row(1'b0, 32'h100, 4'hF, 32'h0, 4'd0);
		add_row(1'b1, 32'h104, 4'hF, 32'h89AB_CDEF, 4'd1);
		add_row(1'b0, 32'h104, 4'hF, 32'h0, 4'd1);
		add_row(1'b1, 32'h108, 4'hF, 32'hA5A5_5A5A, 4'd7);
		add_row(1'b0, 32'h108, 4'hF, 32'h0, 4'd7);
		add_row(1'b1, 32'h10C, 4'hF, 32'hFFFF_0000, 4'd15);
		add_row(1'b0, 32'h10C, 4'hF, 32'h0, 4'd15);
		// partial lanes on write and on read
		add_row(1'b1, 32'h110, 4'hF, 32'h1122_3344, 4'd2);
		add_row(1'b1, 32'h110, 4'b0101, 32'hAABB_CCDD, 4'd3);
		add_row(1'b0, 32'h110, 4'hF, 32'h0, 4'd0);
		add_row(1'b0, 32'h110, 4'b0010, 32'h0, 4'd4);
		add_row(1'b0, 32'h110, 4'b1001, 32'h0, 4'd1);
		// boot fold in both directions
		add_row(1'b1, `BOOT_BASE + 32'h4, 4'hF, 32'hB007_0004, 4'd2);
		add_row(1'b0, 32'h204, 4'hF, 32'h0, 4'd0);
		add_row(1'b1, 32'h208, 4'hF, 32'hDA7A_0208, 4'd1);
		add_row(1'b0, `BOOT_BASE + 32'h8, 4'hF, 32'h0, 4'd5);
		// out of range, data must stay put
		add_row(1'b1, 32'h120, 4'hF, 32'hDEAD_BEEF, 4'd0);
		add_row(1'b1, 32'h920, 4'hF, 32'h0BAD_0BAD, 4'd3);
		add_row(1'b1, 32'h7FE, 4'hF, 32'h0BAD_07FE, 4'd0);
		add_row(1'b1, `BOOT_BASE + 32'h720, 4'hF, 32'h0BAD_B007, 4'd2);
		add_row(1'b0, 32'h800, 4'hF, 32'h0, 4'd6);
		add_row(1'b0, 32'h7FE, 4'hF, 32'h0, 4'd1);
		add_row(1'b0, `BOOT_BASE + 32'h600, 4'hF, 32'h0, 4'd0);
		add_row(1'b0, 32'h120, 4'hF, 32'h0, 4'd2);

		// fill two 64-byte windows so random reads never see unwritten bytes
		for (int w = 0; w < 16; w++) begin
			add_row(1'b1, 32'(w * 4), 4'hF, $urandom, 4'd0);
			add_row(1'b1, 32'h200 + 32'(w * 4), 4'hF, $urandom, 4'd0);
		end
		for (int r = 0; r < random_rows; r++) begin
			offset = $urandom % 61;
			base = ($urandom % 2 == 0) ? 32'h000 : 32'h200;
			// boot alias of the upper window
			if (base != 0 && $urandom % 2 == 0) begin
				base = `BOOT_BASE;
			end
			add_row($urandom % 2 == 1, base + offset, byte_en_t'($urandom), $urandom,
				stall_cnt_t'($urandom));
		end
		table_ready = 1'b1;

		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;
		// idle bus right after reset
		@(negedge clk);
		#1;
		check_level("waitrequest", 1'b0, waitrequest);
		check_word("readdata", '0, readdata);

		foreach (rows[i]) begin
			bus_access(rows[i], cycles, data);
			check_wait(rows[i].exp_wait, cycles);
			if (!rows[i].is_write) begin
				check_word("readdata", rows[i].exp_data, data);
			end
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/bus_mem_pkg.sv
hw/bus_request_decode.sv
hw/wait_state_ctrl.sv
hw/byte_lane_ram.sv
hw/bus_memory.sv
verification/bus_memory_tb.sv
